// File: src/dsp_pkg.sv
package dsp_pkg;

	// one sample lane of an adc or dac word
	localparam int SAMPLE_W = 16;

	// lanes per word on each side of the converters
	localparam int ADC_LANES = 4;
	localparam int DAC_LANES = 16;
	// dac lanes skipped per adc lane when undersampling
	localparam int US_RATIO = DAC_LANES / ADC_LANES;

	// converter counts, fixed by the baseband mux wiring
	localparam int N_ADC = 2;
	localparam int N_DAC = 4;

	// accumulated result, x in the upper half
	localparam int ACC_W = 64;

	typedef logic [ADC_LANES*SAMPLE_W-1:0] adc_word_t;
	typedef logic [DAC_LANES*SAMPLE_W-1:0] dac_word_t;
	typedef logic [ACC_W-1:0] acc_data_t;
	typedef logic [31:0] shot_cnt_t;
	typedef logic [1:0] mix_sel_t;

	// baseband source codes
	localparam mix_sel_t MIX_ADC = 2'd0;
	localparam mix_sel_t MIX_DAC_A = 2'd1;
	localparam mix_sel_t MIX_DAC_B = 2'd2;

	// neighbouring states differ in one bit where the flow allows
	typedef enum logic [2:0] {
		IDLE = 3'b000,
		START = 3'b001,
		PROC_RUN = 3'b011,
		ELEM_BUSY = 3'b010,
		MORE_SHOT = 3'b110,
		SHOT_ADD = 3'b111,
		DONE = 3'b101
	} seq_state_t;

endpackage

// File: src/shot_sequencer.sv
module shot_sequencer import dsp_pkg::*; #(
	parameter int n_proc = 4
) (
	input logic dspif,
	input logic rst,
	input logic stb_start,
	input shot_cnt_t nshot,
	input logic [n_proc-1:0] proc_done,
	input logic [n_proc-1:0] no_busy,
	output logic [n_proc-1:0] proc_reset,
	output logic last_shot_done,
	output shot_cnt_t shot_cnt
);

	seq_state_t state;
	seq_state_t next_state;
	// target latched while idle
	shot_cnt_t nshot_q;
	// running count and its increment, one stage ahead
	shot_cnt_t cnt;
	shot_cnt_t cnt_inc;
	logic more_shot;
	logic proc_done_r;
	logic no_busy_r;
	// single-bit core reset before fan-out
	logic core_rst;
	logic done;

	// all cores must agree, registered to cut the and-tree
	always_ff @(posedge dspif) begin
		if (rst) begin
			proc_done_r <= 1'b0;
			no_busy_r <= 1'b0;
		end else begin
			proc_done_r <= &proc_done;
			no_busy_r <= &no_busy;
		end
	end

	always_ff @(posedge dspif) begin
		if (state == IDLE) begin
			nshot_q <= nshot;
		end
	end

	// compare settled long before MORE_SHOT is reached
	// nshot of 0 means run until rst
	always_ff @(posedge dspif) begin
		cnt_inc <= cnt + shot_cnt_t'(1);
		more_shot <= (cnt_inc != nshot_q) || (nshot_q == '0);
	end

	always_ff @(posedge dspif) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE: next_state = stb_start ? START : IDLE;
			START: next_state = PROC_RUN;
			PROC_RUN: next_state = proc_done_r ? ELEM_BUSY : PROC_RUN;
			ELEM_BUSY: next_state = no_busy_r ? MORE_SHOT : ELEM_BUSY;
			MORE_SHOT: next_state = more_shot ? SHOT_ADD : DONE;
			SHOT_ADD: next_state = START;
			DONE: next_state = IDLE;
			default: next_state = IDLE;
		endcase
	end

	// outputs follow the state being entered
	always_ff @(posedge dspif) begin
		if (rst) begin
			cnt <= '0;
			shot_cnt <= '0;
			core_rst <= 1'b1;
			done <= 1'b0;
		end else begin
			done <= (next_state == DONE);
			// cores run only in START and PROC_RUN
			core_rst <= !(next_state inside {START, PROC_RUN});
			case (next_state)
				IDLE, DONE: cnt <= '0;
				SHOT_ADD: begin
					cnt <= cnt_inc;
					shot_cnt <= cnt_inc;
				end
				default: cnt <= cnt;
			endcase
			// fresh experiment starts counting from zero
			if (state == IDLE && stb_start) begin
				shot_cnt <= '0;
			end
		end
	end

	// second stage toward the cores
	always_ff @(posedge dspif) begin
		if (rst) begin
			proc_reset <= '1;
		end else begin
			proc_reset <= {n_proc{core_rst}};
		end
	end

	// level until the next start, start wins a tie
	always_ff @(posedge dspif) begin
		if (rst || stb_start) begin
			last_shot_done <= 1'b0;
		end else if (done) begin
			last_shot_done <= 1'b1;
		end
	end

	// cores stay held while the machine waits for a start
	a_idle_in_reset: assert property (
		@(posedge dspif) disable iff (rst)
		(state == IDLE) |-> (proc_reset == '1)
	);

endmodule

// File: src/mix_select.sv
module mix_select import dsp_pkg::*; (
	input logic dspif,
	input logic rst,
	input adc_word_t adc [0:N_ADC-1],
	input dac_word_t dac [0:N_DAC-1],
	input mix_sel_t mix_bb1_sel,
	input mix_sel_t mix_bb2_sel,
	output adc_word_t mix_bb1,
	output adc_word_t mix_bb2
);

	adc_word_t adc_q [0:N_ADC-1];
	// dac words cut down to adc lane count
	adc_word_t dac_us [0:N_DAC-1];

	// one source mux, shared by both basebands
	function automatic adc_word_t pick(
		input mix_sel_t sel,
		input adc_word_t a,
		input adc_word_t d0,
		input adc_word_t d1,
		input adc_word_t prev
	);
		case (sel)
			MIX_ADC: pick = a;
			MIX_DAC_A: pick = d0;
			MIX_DAC_B: pick = d1;
			// code 3 keeps the last sample
			default: pick = prev;
		endcase
	endfunction

	// first stage, raw adc and every US_RATIO-th dac lane
	always_ff @(posedge dspif) begin
		adc_q <= adc;
		for (int i = 0; i < N_DAC; i++) begin
			for (int j = 0; j < ADC_LANES; j++) begin
				dac_us[i][j*SAMPLE_W +: SAMPLE_W] <=
					dac[i][j*US_RATIO*SAMPLE_W +: SAMPLE_W];
			end
		end
	end

	// second stage, selected baseband
	always_ff @(posedge dspif) begin
		if (rst) begin
			mix_bb1 <= '0;
			mix_bb2 <= '0;
		end else begin
			// bb1 pairs with dac 0 and 1
			mix_bb1 <= pick(mix_bb1_sel, adc_q[0], dac_us[0], dac_us[1], mix_bb1);
			// bb2 pairs with dac 2 and 3
			mix_bb2 <= pick(mix_bb2_sel, adc_q[1], dac_us[2], dac_us[3], mix_bb2);
		end
	end

endmodule

// File: src/acc_writer.sv
module acc_writer import dsp_pkg::*; #(
	parameter int n_dlo = 4,
	parameter int acc_addr_w = 4
) (
	input logic dspif,
	input logic rst,
	input logic reset_acc,
	input acc_data_t acc_x_y [0:n_dlo-1],
	input logic [n_dlo-1:0] acc_valid,
	output acc_data_t data_accbuf [0:n_dlo-1],
	output logic [acc_addr_w-1:0] addr_accbuf [0:n_dlo-1],
	output logic [n_dlo-1:0] we_accbuf,
	output logic [n_dlo-1:0] meas_bit,
	output logic [n_dlo-1:0] meas_valid
);

	// pointer clear request, one stage late
	logic reset_acc_q;

	always_ff @(posedge dspif) begin
		if (rst) begin
			reset_acc_q <= 1'b0;
		end else begin
			reset_acc_q <= reset_acc;
		end
	end

	for (genvar i = 0; i < n_dlo; i++) begin : g_chan
		// pointer parks on the last location
		logic lock_last;

		assign lock_last = &addr_accbuf[i];

		// result and strobe toward buffer
		always_ff @(posedge dspif) begin
			data_accbuf[i] <= acc_x_y[i];
		end

		always_ff @(posedge dspif) begin
			if (rst) begin
				we_accbuf[i] <= 1'b0;
				addr_accbuf[i] <= '0;
				meas_valid[i] <= 1'b0;
			end else begin
				we_accbuf[i] <= acc_valid[i];
				// clear beats advance
				if (reset_acc_q) begin
					addr_accbuf[i] <= '0;
				end else if (we_accbuf[i] && !lock_last) begin
					addr_accbuf[i] <= addr_accbuf[i] + 1'b1;
				end
				meas_valid[i] <= we_accbuf[i];
			end
		end

		// threshold on the x sign, same cycle as the pointer step
		always_ff @(posedge dspif) begin
			meas_bit[i] <= data_accbuf[i][ACC_W-1];
		end

		// a parked pointer only wraps through a clear
		a_no_wrap: assert property (
			@(posedge dspif) disable iff (rst)
			($past(addr_accbuf[i]) == '1 && addr_accbuf[i] == '0 && !$past(rst))
				|-> $past(reset_acc_q)
		);
	end

endmodule

// File: src/dsp_top.sv
module dsp_top import dsp_pkg::*; #(
	parameter int n_proc = 4,
	parameter int n_dlo = 4,
	parameter int acc_addr_w = 4
) (
	input logic dspif,
	input logic rst,
	// experiment control and core status
	input logic stb_start,
	input shot_cnt_t nshot,
	input logic [n_proc-1:0] proc_done,
	input logic [n_proc-1:0] no_busy,
	output logic [n_proc-1:0] proc_reset,
	output logic last_shot_done,
	output shot_cnt_t shot_cnt,
	// converter words and baseband selects
	input adc_word_t adc [0:N_ADC-1],
	input dac_word_t dac [0:N_DAC-1],
	input mix_sel_t mix_bb1_sel,
	input mix_sel_t mix_bb2_sel,
	output adc_word_t mix_bb1,
	output adc_word_t mix_bb2,
	// accumulator results toward buffer and feedback
	input logic reset_acc,
	input acc_data_t acc_x_y [0:n_dlo-1],
	input logic [n_dlo-1:0] acc_valid,
	output acc_data_t data_accbuf [0:n_dlo-1],
	output logic [acc_addr_w-1:0] addr_accbuf [0:n_dlo-1],
	output logic [n_dlo-1:0] we_accbuf,
	output logic [n_dlo-1:0] meas_bit,
	output logic [n_dlo-1:0] meas_valid
);

	// multi-shot control
	shot_sequencer #(
		.n_proc(n_proc)
	) shot_sequencer_i (
		.dspif(dspif),
		.rst(rst),
		.stb_start(stb_start),
		.nshot(nshot),
		.proc_done(proc_done),
		.no_busy(no_busy),
		.proc_reset(proc_reset),
		.last_shot_done(last_shot_done),
		.shot_cnt(shot_cnt)
	);

	// baseband sources
	mix_select mix_select_i (
		.dspif(dspif),
		.rst(rst),
		.adc(adc),
		.dac(dac),
		.mix_bb1_sel(mix_bb1_sel),
		.mix_bb2_sel(mix_bb2_sel),
		.mix_bb1(mix_bb1),
		.mix_bb2(mix_bb2)
	);

	// per-channel buffer write and threshold
	acc_writer #(
		.n_dlo(n_dlo),
		.acc_addr_w(acc_addr_w)
	) acc_writer_i (
		.dspif(dspif),
		.rst(rst),
		.reset_acc(reset_acc),
		.acc_x_y(acc_x_y),
		.acc_valid(acc_valid),
		.data_accbuf(data_accbuf),
		.addr_accbuf(addr_accbuf),
		.we_accbuf(we_accbuf),
		.meas_bit(meas_bit),
		.meas_valid(meas_valid)
	);

endmodule

// File: testbench/dsp_tb.sv
module dsp_tb import dsp_pkg::*; ();

	localparam int n_proc = 4;
	localparam int n_dlo = 4;
	localparam int acc_addr_w = 4;
	localparam logic [acc_addr_w-1:0] addr_one = 1;

	logic dspif, rst, stb_start, last_shot_done, reset_acc;
	shot_cnt_t nshot, shot_cnt;
	logic [n_proc-1:0] proc_done, no_busy, proc_reset;
	adc_word_t adc [0:N_ADC-1];
	dac_word_t dac [0:N_DAC-1];
	mix_sel_t mix_bb1_sel, mix_bb2_sel;
	adc_word_t mix_bb1, mix_bb2;
	acc_data_t acc_x_y [0:n_dlo-1];
	acc_data_t data_accbuf [0:n_dlo-1];
	logic [acc_addr_w-1:0] addr_accbuf [0:n_dlo-1];
	logic [n_dlo-1:0] acc_valid, we_accbuf, meas_bit, meas_valid;

	logic [31:0] lfsr = 32'd99;
	int errors = 0;
	int tests = 0;
	int failed = 0;
	// per-channel write counts and meas_valid pulses of the last burst
	int writes [0:n_dlo-1];
	int meas_seen;

	dsp_top #(
		.n_proc(n_proc),
		.n_dlo(n_dlo),
		.acc_addr_w(acc_addr_w)
	) dsp_top_i (.*);

	initial begin
		dspif = 1'b0;
		forever #2 dspif = ~dspif;
	end

	// galois form, taps for x^32+x^22+x^2+x+1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	task automatic take_bits(input int n, output logic [255:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v[i] = lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// adc lane j comes from dac lane 4*j
	function automatic adc_word_t undersample(input dac_word_t d);
		adc_word_t r;
		for (int j = 0; j < 4; j++) begin
			r[j*SAMPLE_W +: SAMPLE_W] = d[4*j*SAMPLE_W +: SAMPLE_W];
		end
		return r;
	endfunction

	function automatic adc_word_t select_ref(input mix_sel_t sel, input adc_word_t a,
			input adc_word_t d0, input adc_word_t d1, input adc_word_t prev);
		case (sel)
			2'd0: return a;
			2'd1: return d0;
			2'd2: return d1;
			default: return prev;
		endcase
	endfunction

	// clear wins, then step unless parked at all ones
	function automatic logic [acc_addr_w-1:0] next_addr(input logic [acc_addr_w-1:0] a,
			input logic we, input logic clr);
		if (clr) begin
			return '0;
		end
		if (we && a != '1) begin
			return a + addr_one;
		end
		return a;
	endfunction

	function automatic logic sign_ref(input acc_data_t d);
		return d[63];
	endfunction

	task automatic value_error(input string name, input logic [63:0] got, input logic [63:0] exp);
		$display("FAIL %s got %h expected %h", name, got, exp);
		errors++;
	endtask

	task automatic report_test(input string name, input int err0);
		tests++;
		if (errors == err0) begin
			$display("test %s: passed", name);
		end else begin
			failed++;
			$display("test %s: failed with %0d errors", name, errors - err0);
		end
	endtask

	// core model, done and not-busy after random delays of 1 to 8 cycles
	initial begin : core_model
		int dly;
		logic was_run, run;
		logic [255:0] r;
		proc_done = '0;
		no_busy = '0;
		dly = 0;
		was_run = 1'b0;
		forever begin
			@(posedge dspif);
			#1;
			run = (proc_reset == '0);
			if (run && !was_run) begin
				// cores leave reset busy
				no_busy = '0;
				take_bits(3, r);
				dly = int'(r[2:0]) + 1;
			end else if (!run && was_run) begin
				proc_done = '0;
				take_bits(3, r);
				dly = int'(r[2:0]) + 1;
			end else if (dly > 0) begin
				dly--;
				if (dly == 0 && run) begin
					proc_done = '1;
				end else if (dly == 0) begin
					no_busy = '1;
				end
			end
			was_run = run;
		end
	end

	// reference pipeline, inputs taken at the edge, outputs checked just after
	initial begin : compare
		adc_word_t exp_bb1, exp_bb2;
		adc_word_t adc_d [0:N_ADC-1];
		dac_word_t dac_d [0:N_DAC-1];
		logic [acc_addr_w-1:0] exp_addr [0:n_dlo-1];
		acc_data_t exp_data [0:n_dlo-1];
		logic [n_dlo-1:0] exp_we, exp_mv, exp_mb;
		logic exp_clr, rst_s;
		forever begin
			@(posedge dspif);
			rst_s = rst;
			// old stage values first
			for (int i = 0; i < n_dlo; i++) begin
				exp_mb[i] = sign_ref(exp_data[i]);
				exp_addr[i] = rst_s ? '0 : next_addr(exp_addr[i], exp_we[i], exp_clr);
				exp_data[i] = acc_x_y[i];
			end
			exp_mv = rst_s ? '0 : exp_we;
			exp_we = rst_s ? '0 : acc_valid;
			exp_clr = rst_s ? 1'b0 : reset_acc;
			exp_bb1 = rst_s ? '0 : select_ref(mix_bb1_sel, adc_d[0], undersample(dac_d[0]),
				undersample(dac_d[1]), exp_bb1);
			exp_bb2 = rst_s ? '0 : select_ref(mix_bb2_sel, adc_d[1], undersample(dac_d[2]),
				undersample(dac_d[3]), exp_bb2);
			adc_d = adc;
			dac_d = dac;
			#1;
			if (!rst_s) begin
				assert (mix_bb1 == exp_bb1) else value_error("mix_bb1", mix_bb1, exp_bb1);
				assert (mix_bb2 == exp_bb2) else value_error("mix_bb2", mix_bb2, exp_bb2);
				assert (we_accbuf == exp_we)
					else value_error("we_accbuf", 64'(we_accbuf), 64'(exp_we));
				assert (meas_valid == exp_mv)
					else value_error("meas_valid", 64'(meas_valid), 64'(exp_mv));
				for (int i = 0; i < n_dlo; i++) begin
					assert (addr_accbuf[i] == exp_addr[i])
						else value_error($sformatf("addr_accbuf[%0d]", i),
							64'(addr_accbuf[i]), 64'(exp_addr[i]));
					if (exp_we[i]) begin
						assert (data_accbuf[i] == exp_data[i])
							else value_error($sformatf("data_accbuf[%0d]", i),
								data_accbuf[i], exp_data[i]);
					end
					if (exp_mv[i]) begin
						assert (meas_bit[i] == exp_mb[i])
							else value_error($sformatf("meas_bit[%0d]", i),
								64'(meas_bit[i]), 64'(exp_mb[i]));
					end
				end
			end
		end
	end

	task automatic run_experiment(input int n);
		int err0, windows, cyc;
		logic was_low;
		err0 = errors;
		nshot = shot_cnt_t'(n);
		@(posedge dspif);
		#1;
		stb_start = 1'b1;
		@(posedge dspif);
		#1;
		stb_start = 1'b0;
		// start clears the level of the previous experiment
		assert (last_shot_done == 1'b0)
			else value_error("last_shot_done", 64'(last_shot_done), 64'h0);
		windows = 0;
		cyc = 0;
		was_low = 1'b0;
		while (last_shot_done !== 1'b1 && cyc < 1000) begin
			@(posedge dspif);
			#1;
			cyc++;
			if (proc_reset == '0 && !was_low) begin
				windows++;
			end
			was_low = (proc_reset == '0);
		end
		if (last_shot_done !== 1'b1) begin
			$display("timeout, last_shot_done did not rise within %0d cycles", cyc);
			errors++;
		end
		assert (windows == n) else value_error("proc_reset low windows", 64'(windows), 64'(n));
		assert (shot_cnt == shot_cnt_t'(n - 1))
			else value_error("shot_cnt", 64'(shot_cnt), 64'(n - 1));
		// level holds, cores parked
		repeat (6) begin
			@(posedge dspif);
			#1;
			assert (last_shot_done == 1'b1)
				else value_error("last_shot_done", 64'(last_shot_done), 64'h1);
			assert (proc_reset == '1)
				else value_error("proc_reset", 64'(proc_reset), 64'({n_proc{1'b1}}));
		end
		report_test($sformatf("shot count and done level, nshot %0d", n), err0);
	endtask

	task automatic mix_test();
		int err0;
		logic [255:0] r;
		err0 = errors;
		for (int c = 0; c < 48; c++) begin
			@(posedge dspif);
			#1;
			for (int k = 0; k < N_ADC; k++) begin
				take_bits(64, r);
				adc[k] = r[63:0];
			end
			for (int k = 0; k < N_DAC; k++) begin
				take_bits(256, r);
				dac[k] = r;
			end
			take_bits(4, r);
			// tail parks both selects on hold
			mix_bb1_sel = (c < 40) ? r[1:0] : 2'd3;
			mix_bb2_sel = (c < 40) ? r[3:2] : 2'd3;
		end
		repeat (3) @(posedge dspif);
		report_test("mix selection", err0);
	endtask

	// random acc_valid bursts, then 4 quiet cycles for the pipeline to drain
	task automatic random_writes(input int cycles, input logic dense);
		logic [255:0] r;
		for (int i = 0; i < n_dlo; i++) begin
			writes[i] = 0;
		end
		meas_seen = 0;
		for (int c = 0; c < cycles + 4; c++) begin
			@(posedge dspif);
			#1;
			meas_seen += $countones(meas_valid);
			for (int i = 0; i < n_dlo; i++) begin
				take_bits(2, r);
				acc_valid[i] = (c < cycles) && (dense ? (r[1:0] != 2'b00) : r[0]);
				writes[i] += int'(acc_valid[i]);
				take_bits(64, r);
				acc_x_y[i] = r[63:0];
			end
		end
	endtask

	task automatic write_test();
		int err0;
		logic [acc_addr_w-1:0] exp_a;
		err0 = errors;
		random_writes(80, 1'b1);
		for (int i = 0; i < n_dlo; i++) begin
			exp_a = (writes[i] >= 2**acc_addr_w - 1) ? '1 : acc_addr_w'(writes[i]);
			assert (addr_accbuf[i] == exp_a)
				else value_error($sformatf("addr_accbuf[%0d]", i), 64'(addr_accbuf[i]), 64'(exp_a));
			if (writes[i] <= 2**acc_addr_w) begin
				$display("channel %0d got only %0d writes, the address never locked", i, writes[i]);
				errors++;
			end
		end
		report_test("write path and address", err0);
	endtask

	task automatic clear_test();
		int err0;
		err0 = errors;
		@(posedge dspif);
		#1;
		reset_acc = 1'b1;
		@(posedge dspif);
		#1;
		reset_acc = 1'b0;
		@(posedge dspif);
		#1;
		for (int i = 0; i < n_dlo; i++) begin
			assert (addr_accbuf[i] == '0)
				else value_error($sformatf("addr_accbuf[%0d]", i), 64'(addr_accbuf[i]), 64'h0);
		end
		// first write after the clear lands at 0
		acc_valid = '1;
		@(posedge dspif);
		#1;
		acc_valid = '0;
		assert (we_accbuf == '1) else value_error("we_accbuf", 64'(we_accbuf), 64'hf);
		for (int i = 0; i < n_dlo; i++) begin
			assert (addr_accbuf[i] == '0)
				else value_error($sformatf("addr_accbuf[%0d]", i), 64'(addr_accbuf[i]), 64'h0);
		end
		@(posedge dspif);
		#1;
		for (int i = 0; i < n_dlo; i++) begin
			assert (addr_accbuf[i] == addr_one)
				else value_error($sformatf("addr_accbuf[%0d]", i), 64'(addr_accbuf[i]), 64'h1);
		end
		report_test("reset_acc clear", err0);
	endtask

	task automatic threshold_test();
		int err0, total;
		err0 = errors;
		random_writes(40, 1'b0);
		total = 0;
		for (int i = 0; i < n_dlo; i++) begin
			total += writes[i];
		end
		// sign bits themselves checked by the compare process
		assert (meas_seen == total)
			else value_error("meas_valid pulse count", 64'(meas_seen), 64'(total));
		report_test("threshold", err0);
	endtask

	initial begin : stimulus
		int err0;
		rst = 1'b1;
		stb_start = 1'b0;
		nshot = '0;
		mix_bb1_sel = '0;
		mix_bb2_sel = '0;
		reset_acc = 1'b0;
		acc_valid = '0;
		for (int k = 0; k < N_ADC; k++) begin
			adc[k] = '0;
		end
		for (int k = 0; k < N_DAC; k++) begin
			dac[k] = '0;
		end
		for (int i = 0; i < n_dlo; i++) begin
			acc_x_y[i] = '0;
		end
		repeat (5) @(posedge dspif);
		#1;
		rst = 1'b0;
		err0 = errors;
		assert (proc_reset == '1)
			else value_error("proc_reset", 64'(proc_reset), 64'({n_proc{1'b1}}));
		assert (last_shot_done == 1'b0)
			else value_error("last_shot_done", 64'(last_shot_done), 64'h0);
		assert (shot_cnt == '0) else value_error("shot_cnt", 64'(shot_cnt), 64'h0);
		report_test("reset state", err0);
		run_experiment(1);
		run_experiment(3);
		run_experiment(5);
		mix_test();
		write_test();
		clear_test();
		threshold_test();
		$display("summary: %0d tests, %0d failed, %0d errors", tests, failed, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: filelist.f
src/dsp_pkg.sv
src/shot_sequencer.sv
src/mix_select.sv
src/acc_writer.sv
src/dsp_top.sv
testbench/dsp_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = dsp_tb
FILELIST = filelist.f
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG) || ! grep -q "RESULT: PASS" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
